// ==== tb.f ====
common/hex_display_pkg.sv
common/glyph_if.sv
rtl/raster_counter.sv
rtl/sync_gen.sv
glyph/glyph_fetch.sv
rtl/pixel_compose.sv
rtl/hex_display_top.sv
testbench/pixel_checker.sv
testbench/tb_hex_display.sv

// ==== testbench/tb_hex_display.sv ====
`default_nettype none

module tb_hex_display;
	timeunit 1ns;
	timeprecision 100ps;
	import hex_display_pkg::*;

	localparam int          CLK_PERIOD   = 4;
	localparam int          DRIVE_DELAY  = 1;
	localparam int          RESET_CYCLES = 2;
	localparam int          N_FRAMES     = 3;
	localparam int          PIPE_DEPTH   = 2;
	localparam logic [31:0] LFSR_SEED    = 32'd88084;
	localparam int RUN_CYCLES  = RESET_CYCLES + N_FRAMES * H_TOTAL * V_TOTAL + PIPE_DEPTH + 1;
	localparam int WATCHDOG_NS = RUN_CYCLES * CLK_PERIOD * 6 / 5;  // About 20 % headroom

	logic         pixel_clk = 1'b0;
	logic         rst;
	display_vec_t display_values;
	color_t       vga_r, vga_g, vga_b;
	logic         vga_hs, vga_vs;
	logic         check_failed;
	logic [31:0]  lfsr;

	always #(CLK_PERIOD / 2) pixel_clk = ~pixel_clk;

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
	endfunction

	task automatic draw_display_values();
		for (int i = 0; i < $bits(display_vec_t); i++) begin
			lfsr = lfsr_next(lfsr);
			display_values[i] = lfsr[0];
		end
	endtask

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Regression failed");
		$fatal(1);
	endtask

	hex_display_top DUT (
		.pixel_clk      (pixel_clk),
		.rst            (rst),
		.display_values (display_values),
		.vga_r          (vga_r),
		.vga_g          (vga_g),
		.vga_b          (vga_b),
		.vga_hs         (vga_hs),
		.vga_vs         (vga_vs)
	);

	pixel_checker u_checker (
		.pixel_clk      (pixel_clk),
		.rst            (rst),
		.display_values (display_values),
		.vga_r          (vga_r),
		.vga_g          (vga_g),
		.vga_b          (vga_b),
		.vga_hs         (vga_hs),
		.vga_vs         (vga_vs),
		.check_failed   (check_failed)
	);

	initial begin
		rst = 1'b1;
		lfsr = LFSR_SEED;
		display_values = '0;
		draw_display_values();
		repeat (RESET_CYCLES) @(posedge pixel_clk);
		#DRIVE_DELAY rst = 1'b0;
		// Loop indices track the position shown by the raster counter
		for (int frame = 0; frame < N_FRAMES; frame++) begin
			for (int v = 0; v < V_TOTAL; v++) begin
				for (int h = 0; h < H_TOTAL; h++) begin
					if (h == 0 && v == V_ACTIVE)
						draw_display_values();  // New values during vertical blanking
					@(posedge pixel_clk);
					#DRIVE_DELAY;
				end
			end
		end
		repeat (PIPE_DEPTH + 1) @(posedge pixel_clk);  // Drain the last positions
		#DRIVE_DELAY;
		if (check_failed) begin
			stop_with_failure("Pixel checker reported a mismatch");
		end else begin
			$display("Regression passed");
			$finish;
		end
	end

	initial begin
		@(posedge check_failed);
		stop_with_failure("Stopping at the first output mismatch");
	end

	initial begin
		#(WATCHDOG_NS);
		stop_with_failure("Timeout: the run did not reach its end in time");
	end

endmodule

`default_nettype wire

// ==== testbench/pixel_checker.sv ====
`default_nettype none

module pixel_checker (
	input  wire                                pixel_clk,
	input  wire                                rst,
	input  wire hex_display_pkg::display_vec_t display_values,
	input  wire hex_display_pkg::color_t       vga_r,
	input  wire hex_display_pkg::color_t       vga_g,
	input  wire hex_display_pkg::color_t       vga_b,
	input  wire                                vga_hs,
	input  wire                                vga_vs,
	output logic                               check_failed
);
	timeunit 1ns;
	timeprecision 100ps;
	import hex_display_pkg::*;

	localparam int CELL_W  = int'(REG_WIDTH);
	localparam int CELL_H  = int'(REG_HEIGHT);
	localparam int DIGIT_W = int'(DIGIT_WIDTH);
	localparam int DOT_X0  = int'(GLYPH_X0);
	localparam int DOT_W   = int'(GLYPH_DOT);
	localparam int DOT_H   = int'(GLYPH_LINE);

	coord_t       m_h, m_v;    // Raster position model
	coord_t       d1_h, d1_v;
	coord_t       d2_h, d2_v;  // Position now at the DUT outputs
	display_vec_t dv1, dv2;
	logic         val1, val2;
	logic         armed = 1'b0;
	color_t       exp_level;
	logic         exp_hs, exp_vs;

	initial check_failed = 1'b0;

	// Font bit under pixel (h, v), zero outside the dot area of a digit
	function automatic logic font_pixel_on(input int h, input int v, input display_vec_t dv);
		int col;
		int row;
		int off;
		int dig;
		int dot;
		int frow;
		int fcol;
		logic [3:0] nib;
		col = (h / CELL_W > REG_COLS - 1) ? REG_COLS - 1 : h / CELL_W;
		row = (v / CELL_H > 1) ? 1 : v / CELL_H;
		off = h % CELL_W;
		dig = (off / DIGIT_W > REG_DIGITS - 1) ? REG_DIGITS - 1 : off / DIGIT_W;
		dot = off - dig * DIGIT_W;
		frow = (v % CELL_H) / DOT_H;
		if (dot < DOT_X0 || dot >= DOT_X0 + 8 * DOT_W)
			return 1'b0;
		fcol = (dot - DOT_X0) / DOT_W;
		nib = dv[(row * REG_COLS + col) * 16 + (3 - dig) * 4 +: 4];  // Digit 0 is the top nibble
		return HEX_FONT[nib][frow][7 - fcol];
	endfunction

	function automatic color_t expected_level(input int h, input int v, input display_vec_t dv);
		if (h >= H_ACTIVE || v >= V_ACTIVE)
			return '0;
		if (h == CELL_W || h == 2 * CELL_W)
			return '1;  // Column divider
		return font_pixel_on(h, v, dv) ? '1 : '0;
	endfunction

	task automatic report_mismatch(input string name, input int expected, input int actual);
		$display("Fail at %0.1f ns: %s expected %0d, got %0d", $realtime, name, expected, actual);
		check_failed = 1'b1;
	endtask

	always_ff @(posedge pixel_clk) begin
		armed <= 1'b1;
		if (rst) begin
			m_h  <= '0;
			m_v  <= '0;
			val1 <= 1'b0;
			val2 <= 1'b0;
		end else begin
			m_h  <= (m_h == H_TOTAL - 1) ? '0 : m_h + 1'b1;
			if (m_h == H_TOTAL - 1)
				m_v <= (m_v == V_TOTAL - 1) ? '0 : m_v + 1'b1;
			val1 <= 1'b1;
			val2 <= val1;  // Outputs valid two cycles after reset
		end
		d1_h <= m_h;
		d1_v <= m_v;
		dv1  <= display_values;
		d2_h <= d1_h;
		d2_v <= d1_v;
		dv2  <= dv1;
	end

	always_comb begin
		exp_level = val2 ? expected_level(int'(d2_h), int'(d2_v), dv2) : '0;
		exp_hs    = !(val2 && d2_h >= H_SYNC_START && d2_h < H_SYNC_END);  // Active low
		exp_vs    = !(val2 && d2_v >= V_SYNC_START && d2_v < V_SYNC_END);
	end

	a_vga_r: assert property (@(posedge pixel_clk) armed |-> vga_r == exp_level)
		else report_mismatch("vga_r", $sampled(exp_level), $sampled(vga_r));
	a_vga_g: assert property (@(posedge pixel_clk) armed |-> vga_g == exp_level)
		else report_mismatch("vga_g", $sampled(exp_level), $sampled(vga_g));
	a_vga_b: assert property (@(posedge pixel_clk) armed |-> vga_b == exp_level)
		else report_mismatch("vga_b", $sampled(exp_level), $sampled(vga_b));
	a_vga_hs: assert property (@(posedge pixel_clk) armed |-> vga_hs == exp_hs)
		else report_mismatch("vga_hs", $sampled(exp_hs), $sampled(vga_hs));
	a_vga_vs: assert property (@(posedge pixel_clk) armed |-> vga_vs == exp_vs)
		else report_mismatch("vga_vs", $sampled(exp_vs), $sampled(vga_vs));

endmodule

`default_nettype wire

// ==== rtl/hex_display_top.sv ====
`default_nettype none

// Hex register overlay for 640x480 VGA
module hex_display_top (
	input  wire                           pixel_clk,
	input  wire                           rst,
	input  wire hex_display_pkg::display_vec_t display_values,
	output hex_display_pkg::color_t       vga_r,
	output hex_display_pkg::color_t       vga_g,
	output hex_display_pkg::color_t       vga_b,
	output logic                          vga_hs,
	output logic                          vga_vs
);
	import hex_display_pkg::*;

	coord_t h_count;
	coord_t v_count;
	logic   sync_h;
	logic   sync_v;
	logic   active;

	glyph_if glyph_bus ();

	raster_counter #(
		.H_TOTAL (H_TOTAL),
		.V_TOTAL (V_TOTAL)
	) u_raster (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.h_count   (h_count),
		.v_count   (v_count)
	);

	// Timing and glyph decode run side by side on the same position
	sync_gen #(
		.H_ACTIVE     (H_ACTIVE),
		.V_ACTIVE     (V_ACTIVE),
		.H_SYNC_START (H_SYNC_START),
		.H_SYNC_END   (H_SYNC_END),
		.V_SYNC_START (V_SYNC_START),
		.V_SYNC_END   (V_SYNC_END)
	) u_sync (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.h_count   (h_count),
		.v_count   (v_count),
		.sync_h    (sync_h),
		.sync_v    (sync_v),
		.active    (active)
	);

	glyph_fetch u_glyph (
		.pixel_clk      (pixel_clk),
		.rst            (rst),
		.h_count        (h_count),
		.v_count        (v_count),
		.display_values (display_values),
		.glyph          (glyph_bus.source)
	);

	pixel_compose u_compose (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.sync_h    (sync_h),
		.sync_v    (sync_v),
		.active    (active),
		.glyph     (glyph_bus.sink),
		.vga_r     (vga_r),
		.vga_g     (vga_g),
		.vga_b     (vga_b),
		.vga_hs    (vga_hs),
		.vga_vs    (vga_vs)
	);

endmodule

`default_nettype wire

// ==== rtl/pixel_compose.sv ====
`default_nettype none

module pixel_compose (
	input  wire                     pixel_clk,
	input  wire                     rst,
	input  wire                     sync_h,
	input  wire                     sync_v,
	input  wire                     active,
	glyph_if.sink                   glyph,
	output hex_display_pkg::color_t vga_r,
	output hex_display_pkg::color_t vga_g,
	output hex_display_pkg::color_t vga_b,
	output logic                    vga_hs,
	output logic                    vga_vs
);
	import hex_display_pkg::*;

	localparam int ROW_MSB = $bits(glyph_row_t) - 1;

	logic   font_bit;
	logic   pix_on;
	color_t level;

	assign font_bit = glyph.glyph_row[ROW_MSB - glyph.dot_index];  // Column 0 is the MSB
	assign pix_on   = active && (glyph.divider || (glyph.in_glyph && font_bit));
	assign level    = pix_on ? '1 : '0;  // Monochrome, white or black

	always_ff @(posedge pixel_clk) begin
		if (rst) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_hs <= 1'b1;
			vga_vs <= 1'b1;
		end else begin
			vga_r  <= level;
			vga_g  <= level;
			vga_b  <= level;
			vga_hs <= sync_h;  // Keeps sync aligned with the pixel data
			vga_vs <= sync_v;
		end
	end

endmodule

`default_nettype wire

// ==== glyph/glyph_fetch.sv ====
`default_nettype none

module glyph_fetch (
	input  wire                           pixel_clk,
	input  wire                           rst,
	input  wire hex_display_pkg::coord_t       h_count,
	input  wire hex_display_pkg::coord_t       v_count,
	input  wire hex_display_pkg::display_vec_t display_values,
	glyph_if.source                       glyph
);
	import hex_display_pkg::*;

	localparam int REG_BITS = $bits(nibble_t) * REG_DIGITS;

	coord_t     col_div;
	coord_t     offset;     // Pixel offset inside the register cell
	coord_t     digit_div;
	coord_t     dot_off;    // Pixel offset inside the digit cell
	coord_t     line_off;
	coord_t     font_line;
	coord_t     dot_col;
	logic [1:0] reg_col;
	logic       reg_row;
	logic [2:0] reg_idx;
	logic [1:0] digit;
	logic [REG_BITS-1:0] reg_val;
	nibble_t    digit_val;
	logic [3:0] font_row;
	logic       in_glyph_c;
	logic       divider_c;

	always_comb begin
		// Register cell, the right edge folds into the last column
		col_div = h_count / REG_WIDTH;
		offset  = h_count % REG_WIDTH;
		reg_col = (col_div >= REG_COLS) ? 2'(REG_COLS - 1) : col_div[1:0];
		reg_row = (v_count / REG_HEIGHT) != '0;
		reg_idx = 3'(REG_COLS) * {2'b00, reg_row} + {1'b0, reg_col};

		// Digit cell, digit 0 is the leftmost
		digit_div = offset / DIGIT_WIDTH;
		digit     = (digit_div >= REG_DIGITS) ? 2'(REG_DIGITS - 1) : digit_div[1:0];
		dot_off   = offset - DIGIT_WIDTH * digit;

		line_off  = v_count % REG_HEIGHT;
		font_line = line_off / GLYPH_LINE;
		font_row  = font_line[3:0];

		dot_col    = (dot_off - GLYPH_X0) / GLYPH_DOT;
		in_glyph_c = (dot_off >= GLYPH_X0) && (dot_off < GLYPH_X0 + 8 * GLYPH_DOT);
		divider_c  = (h_count == REG_WIDTH) || (h_count == 2 * REG_WIDTH);

		reg_val   = display_values[reg_idx * REG_BITS +: REG_BITS];
		digit_val = reg_val[(REG_DIGITS - 1 - digit) * $bits(nibble_t) +: $bits(nibble_t)];
	end

	always_ff @(posedge pixel_clk) begin
		if (rst) begin
			glyph.glyph_row <= '0;
			glyph.dot_index <= '0;
			glyph.in_glyph  <= 1'b0;
			glyph.divider   <= 1'b0;
		end else begin
			glyph.glyph_row <= HEX_FONT[digit_val][font_row];
			glyph.dot_index <= dot_col[2:0];
			glyph.in_glyph  <= in_glyph_c;
			glyph.divider   <= divider_c;
		end
	end

	// Glyph span must map onto the 8 font columns without truncation
	a_dot_in_font: assert property (@(posedge pixel_clk) disable iff (rst)
		in_glyph_c |-> dot_col < 8)
		else $error("dot column %0d beyond font width", dot_col);

endmodule

`default_nettype wire

// ==== rtl/sync_gen.sv ====
`default_nettype none

module sync_gen #(
	parameter int H_ACTIVE     = hex_display_pkg::H_ACTIVE,
	parameter int V_ACTIVE     = hex_display_pkg::V_ACTIVE,
	parameter int H_SYNC_START = hex_display_pkg::H_SYNC_START,
	parameter int H_SYNC_END   = hex_display_pkg::H_SYNC_END,
	parameter int V_SYNC_START = hex_display_pkg::V_SYNC_START,
	parameter int V_SYNC_END   = hex_display_pkg::V_SYNC_END
) (
	input  wire                     pixel_clk,
	input  wire                     rst,
	input  wire hex_display_pkg::coord_t h_count,
	input  wire hex_display_pkg::coord_t v_count,
	output logic                    sync_h,
	output logic                    sync_v,
	output logic                    active
);

	logic h_pulse;
	logic v_pulse;
	logic in_active;

	assign h_pulse   = (h_count >= H_SYNC_START) && (h_count < H_SYNC_END);
	assign v_pulse   = (v_count >= V_SYNC_START) && (v_count < V_SYNC_END);
	assign in_active = (h_count < H_ACTIVE) && (v_count < V_ACTIVE);

	// Sync pulses are active low
	always_ff @(posedge pixel_clk) begin
		if (rst) begin
			sync_h <= 1'b1;
			sync_v <= 1'b1;
			active <= 1'b0;
		end else begin
			sync_h <= ~h_pulse;
			sync_v <= ~v_pulse;
			active <= in_active;
		end
	end

	// Horizontal sync must sit in the blanking interval
	a_no_sync_in_active: assert property (@(posedge pixel_clk) disable iff (rst)
		active |-> sync_h)
		else $error("hsync asserted inside active video");

endmodule

`default_nettype wire

// ==== rtl/raster_counter.sv ====
`default_nettype none

module raster_counter #(
	parameter int H_TOTAL = hex_display_pkg::H_TOTAL,
	parameter int V_TOTAL = hex_display_pkg::V_TOTAL
) (
	input  wire                     pixel_clk,
	input  wire                     rst,
	output hex_display_pkg::coord_t h_count,
	output hex_display_pkg::coord_t v_count
);
	import hex_display_pkg::*;

	logic h_last;
	logic v_last;

	assign h_last = (h_count == coord_t'(H_TOTAL - 1));  // Last pixel of a line
	assign v_last = (v_count == coord_t'(V_TOTAL - 1));  // Last line of a frame

	always_ff @(posedge pixel_clk) begin
		if (rst) begin
			h_count <= '0;
			v_count <= '0;
		end else begin
			h_count <= h_last ? '0 : h_count + 1'b1;
			if (h_last) begin
				v_count <= v_last ? '0 : v_count + 1'b1;  // Line advance on h wrap
			end
		end
	end

	a_h_range: assert property (@(posedge pixel_clk) disable iff (rst) h_count < H_TOTAL)
		else $error("h_count out of range: %0d", h_count);
	a_v_range: assert property (@(posedge pixel_clk) disable iff (rst) v_count < V_TOTAL)
		else $error("v_count out of range: %0d", v_count);

endmodule

`default_nettype wire

// ==== common/glyph_if.sv ====
`default_nettype none

// Per-pixel glyph stage results, one position per cycle
interface glyph_if;
	import hex_display_pkg::*;

	glyph_row_t glyph_row;   // Font row of the current digit
	logic [2:0] dot_index;   // Font column, 0 is the MSB
	logic       in_glyph;    // Inside the 48 dot pixels of a digit
	logic       divider;     // Register column boundary

	modport source (output glyph_row, output dot_index, output in_glyph, output divider);
	modport sink (input glyph_row, input dot_index, input in_glyph, input divider);

endinterface

`default_nettype wire

// ==== common/hex_display_pkg.sv ====
`default_nettype none

package hex_display_pkg;

	typedef logic [10:0] coord_t;        // Raster count, h or v
	typedef logic [3:0]  nibble_t;       // One hex digit
	typedef logic [7:0]  glyph_row_t;    // Leftmost pixel in the MSB
	typedef logic [3:0]  color_t;
	typedef logic [95:0] display_vec_t;  // Six 16-bit registers, reg 0 in the low bits

	// 640x480 at 60 Hz
	localparam int H_ACTIVE     = 640;
	localparam int V_ACTIVE     = 480;
	localparam int H_TOTAL      = 800;
	localparam int V_TOTAL      = 525;
	localparam int H_SYNC_START = 648;
	localparam int H_SYNC_END   = 744;
	localparam int V_SYNC_START = 482;
	localparam int V_SYNC_END   = 484;

	// Screen is split into 3 x 2 register cells, 4 digits per cell
	localparam coord_t REG_WIDTH   = 11'd213;
	localparam coord_t REG_HEIGHT  = 11'd240;
	localparam coord_t DIGIT_WIDTH = 11'd53;
	localparam coord_t GLYPH_X0    = 11'd3;   // Left margin inside a digit cell
	localparam coord_t GLYPH_DOT   = 11'd6;   // Pixels per font column
	localparam coord_t GLYPH_LINE  = 11'd15;  // Lines per font row
	localparam int     REG_COLS    = 3;
	localparam int     REG_DIGITS  = 4;

	// 8x16 font, glyph body in rows 2 to 11
	localparam glyph_row_t HEX_FONT [16][16] = '{
		'{8'h00, 8'h00, 8'h7C, 8'hC6, 8'hC6, 8'hCE, 8'hDE, 8'hF6,
		  8'hE6, 8'hC6, 8'hC6, 8'h7C, 8'h00, 8'h00, 8'h00, 8'h00},  // 0
		'{8'h00, 8'h00, 8'h18, 8'h38, 8'h78, 8'h18, 8'h18, 8'h18,
		  8'h18, 8'h18, 8'h18, 8'h7E, 8'h00, 8'h00, 8'h00, 8'h00},  // 1
		'{8'h00, 8'h00, 8'h7C, 8'hC6, 8'h06, 8'h0C, 8'h18, 8'h30,
		  8'h60, 8'hC0, 8'hC6, 8'hFE, 8'h00, 8'h00, 8'h00, 8'h00},  // 2
		'{8'h00, 8'h00, 8'h7C, 8'hC6, 8'h06, 8'h06, 8'h3C, 8'h06,
		  8'h06, 8'h06, 8'hC6, 8'h7C, 8'h00, 8'h00, 8'h00, 8'h00},  // 3
		'{8'h00, 8'h00, 8'h0C, 8'h1C, 8'h3C, 8'h6C, 8'hCC, 8'hFE,
		  8'h0C, 8'h0C, 8'h0C, 8'h1E, 8'h00, 8'h00, 8'h00, 8'h00},  // 4
		'{8'h00, 8'h00, 8'hFE, 8'hC0, 8'hC0, 8'hC0, 8'hFC, 8'h06,
		  8'h06, 8'h06, 8'hC6, 8'h7C, 8'h00, 8'h00, 8'h00, 8'h00},  // 5
		'{8'h00, 8'h00, 8'h38, 8'h60, 8'hC0, 8'hC0, 8'hFC, 8'hC6,
		  8'hC6, 8'hC6, 8'hC6, 8'h7C, 8'h00, 8'h00, 8'h00, 8'h00},  // 6
		'{8'h00, 8'h00, 8'hFE, 8'hC6, 8'h06, 8'h06, 8'h0C, 8'h18,
		  8'h30, 8'h30, 8'h30, 8'h30, 8'h00, 8'h00, 8'h00, 8'h00},  // 7
		'{8'h00, 8'h00, 8'h7C, 8'hC6, 8'hC6, 8'hC6, 8'h7C, 8'hC6,
		  8'hC6, 8'hC6, 8'hC6, 8'h7C, 8'h00, 8'h00, 8'h00, 8'h00},  // 8
		'{8'h00, 8'h00, 8'h7C, 8'hC6, 8'hC6, 8'hC6, 8'h7E, 8'h06,
		  8'h06, 8'h06, 8'h0C, 8'h78, 8'h00, 8'h00, 8'h00, 8'h00},  // 9
		'{8'h00, 8'h00, 8'h10, 8'h38, 8'h6C, 8'hC6, 8'hC6, 8'hFE,
		  8'hC6, 8'hC6, 8'hC6, 8'hC6, 8'h00, 8'h00, 8'h00, 8'h00},  // A
		'{8'h00, 8'h00, 8'hFC, 8'h66, 8'h66, 8'h66, 8'h7C, 8'h66,
		  8'h66, 8'h66, 8'h66, 8'hFC, 8'h00, 8'h00, 8'h00, 8'h00},  // B
		'{8'h00, 8'h00, 8'h3C, 8'h66, 8'hC2, 8'hC0, 8'hC0, 8'hC0,
		  8'hC0, 8'hC2, 8'h66, 8'h3C, 8'h00, 8'h00, 8'h00, 8'h00},  // C
		'{8'h00, 8'h00, 8'hF8, 8'h6C, 8'h66, 8'h66, 8'h66, 8'h66,
		  8'h66, 8'h66, 8'h6C, 8'hF8, 8'h00, 8'h00, 8'h00, 8'h00},  // D
		'{8'h00, 8'h00, 8'hFE, 8'h66, 8'h62, 8'h68, 8'h78, 8'h68,
		  8'h60, 8'h62, 8'h66, 8'hFE, 8'h00, 8'h00, 8'h00, 8'h00},  // E
		'{8'h00, 8'h00, 8'hFE, 8'h66, 8'h62, 8'h68, 8'h78, 8'h68,
		  8'h60, 8'h60, 8'h60, 8'hF0, 8'h00, 8'h00, 8'h00, 8'h00}   // F
	};

endpackage

`default_nettype wire
